/* Bender.yml */
package:
  name: cin_link

sources:
  # Package and interface first, then the design bottom up
  - src/cin_pkg.sv
  - src/cin_word_if.sv
  - src/srlvec.sv
  - src/cin_parallel_sync.sv
  - src/cin_biterr_counter.sv
  - src/cin_command_decoder.sv
  - src/cin_link_top.sv
  - target: test
    files:
      - tb/tb_cin_link.sv

/* all.f */
src/cin_pkg.sv
src/cin_word_if.sv
src/srlvec.sv
src/cin_parallel_sync.sv
src/cin_biterr_counter.sv
src/cin_command_decoder.sv
src/cin_link_top.sv
tb/tb_cin_link.sv

/* src/cin_biterr_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module cin_biterr_counter (
    input  logic                              sysclk_i,
    input  logic                              rst_i,
    input  logic                              clr_i,
    cin_word_if.err                           e,
    output logic [cin_pkg::CIN_ERRCNT_W-1:0]  count_o
);
    import cin_pkg::*;

    logic [CIN_ERRCNT_W-1:0] count_q;
    logic                    inc_w;
    logic                    sat_w;

    // Errors only mean something on the unlocked training stream
    assign inc_w = e.biterr && !e.locked;
    assign sat_w = (count_q == {CIN_ERRCNT_W{1'b1}});

    // Clear wins over a coincident error pulse
    always_ff @(posedge sysclk_i) begin
        if (rst_i || clr_i) begin
            count_q <= '0;
        end else if (inc_w && !sat_w) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign count_o = count_q;

    // Count is monotonic between clears
    a_no_decrease: assert property (
        @(posedge sysclk_i) disable iff (rst_i)
        !clr_i |=> count_o >= $past(count_o)
    );

endmodule

`default_nettype wire

/* src/cin_command_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module cin_command_decoder (
    input  logic                            sysclk_i,
    input  logic                            rst_i,
    cin_word_if.dec                         d,
    output logic                            trig_o,
    output logic [cin_pkg::CIN_TAG_W-1:0]   trig_tag_o,
    output logic                            wr_o,
    output logic [cin_pkg::CIN_ADDR_W-1:0]  wr_addr_o,
    output logic [cin_pkg::CIN_DATA_W-1:0]  wr_data_o,
    output logic                            runrst_o,
    output logic                            bad_op_o
);
    import cin_pkg::*;

    cin_op_e op_w;
    logic    take_w;
    logic    strobe_any_w;

    // Top byte taken as an opcode, may land outside the enum
    assign op_w   = cin_op_e'(d.word[CIN_WORD_W-1 -: CIN_OP_W]);
    assign take_w = d.valid && d.locked;

    // Strobes, one cycle after the word
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            trig_o   <= 1'b0;
            wr_o     <= 1'b0;
            runrst_o <= 1'b0;
            bad_op_o <= 1'b0;
        end else begin
            trig_o   <= 1'b0;
            wr_o     <= 1'b0;
            runrst_o <= 1'b0;
            bad_op_o <= 1'b0;
            if (take_w) begin
                case (op_w)
                    CIN_OP_TRIG:   trig_o   <= 1'b1;
                    CIN_OP_WRITE:  wr_o     <= 1'b1;
                    CIN_OP_RUNRST: runrst_o <= 1'b1;
                    // Training filler, nothing to do
                    CIN_OP_IDLE:   ;
                    default:       bad_op_o <= 1'b1;
                endcase
            end
        end
    end

    // Payloads load with their strobe and hold otherwise
    always_ff @(posedge sysclk_i) begin
        if (take_w && op_w == CIN_OP_TRIG) begin
            trig_tag_o <= d.word[CIN_TAG_W-1:0];
        end
        if (take_w && op_w == CIN_OP_WRITE) begin
            // Address sits right above the data field
            wr_addr_o <= d.word[CIN_DATA_W +: CIN_ADDR_W];
            wr_data_o <= d.word[CIN_DATA_W-1:0];
        end
    end

    assign strobe_any_w = trig_o || wr_o || runrst_o || bad_op_o;

    // Each strobe answers exactly one locked word from the cycle before
    a_one_strobe: assert property (
        @(posedge sysclk_i) disable iff (rst_i)
        strobe_any_w |-> $onehot0({trig_o, wr_o, runrst_o, bad_op_o})
                         && $past(d.valid && d.locked)
    );

endmodule

`default_nettype wire

/* src/cin_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cin_link_top (
    input  logic                              sysclk_i,
    input  logic                              rst_i,
    input  logic [cin_pkg::CIN_NIB_W-1:0]     cin_i,
    input  logic                              lock_i,
    input  logic                              errcnt_clr_i,
    output logic                              locked_o,
    output logic [cin_pkg::CIN_ERRCNT_W-1:0]  errcnt_o,
    output logic                              trig_o,
    output logic [cin_pkg::CIN_TAG_W-1:0]     trig_tag_o,
    output logic                              wr_o,
    output logic [cin_pkg::CIN_ADDR_W-1:0]    wr_addr_o,
    output logic [cin_pkg::CIN_DATA_W-1:0]    wr_data_o,
    output logic                              runrst_o,
    output logic                              bad_op_o
);

    // Word, lock and error signals out of the sync block
    cin_word_if u_word_if ();

    // Nibble stream to words
    cin_parallel_sync u_sync (
        .sysclk_i (sysclk_i),
        .rst_i    (rst_i),
        .cin_i    (cin_i),
        .lock_i   (lock_i),
        .w        (u_word_if.src)
    );

    // Training error statistics
    cin_biterr_counter u_errcnt (
        .sysclk_i (sysclk_i),
        .rst_i    (rst_i),
        .clr_i    (errcnt_clr_i),
        .e        (u_word_if.err),
        .count_o  (errcnt_o)
    );

    // Words to command strobes
    cin_command_decoder u_dec (
        .sysclk_i   (sysclk_i),
        .rst_i      (rst_i),
        .d          (u_word_if.dec),
        .trig_o     (trig_o),
        .trig_tag_o (trig_tag_o),
        .wr_o       (wr_o),
        .wr_addr_o  (wr_addr_o),
        .wr_data_o  (wr_data_o),
        .runrst_o   (runrst_o),
        .bad_op_o   (bad_op_o)
    );

    assign locked_o = u_word_if.locked;

endmodule

`default_nettype wire

/* src/cin_parallel_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module cin_parallel_sync (
    input  logic                         sysclk_i,
    input  logic                         rst_i,
    input  logic [cin_pkg::CIN_NIB_W-1:0] cin_i,
    input  logic                         lock_i,
    cin_word_if.src                      w
);
    import cin_pkg::*;

    // Previous seven nibbles with the oldest in the low bits
    logic [CIN_HIST_W-1:0] hist_q;
    // Word ending with the nibble arriving this cycle
    logic [CIN_WORD_W-1:0] cand_w;
    logic [CIN_WORD_W-1:0] capture_q;

    cin_lock_e state_q;
    cin_lock_e state_d;

    // Frame position with bit 3 as the valid pulse
    logic [3:0] seq_q;
    logic       capture_w;

    // Bit error path
    logic [CIN_NIB_W-1:0]           oldest_dly_w;
    logic [3:0]                     prime_q;
    logic                           biterr_q;

    // Nibbles arrive LS first, so shift right
    always_ff @(posedge sysclk_i) begin
        hist_q <= {cin_i, hist_q[CIN_HIST_W-1:CIN_NIB_W]};
    end

    assign cand_w = {cin_i, hist_q};

    // Lock FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            LK_IDLE: begin
                if (lock_i) begin
                    state_d = LK_ARMED;
                end
            end
            LK_ARMED: begin
                // Lock on the edge that completes a training word
                if (cand_w == CIN_TRAIN_WORD) begin
                    state_d = LK_LOCKED;
                end
            end
            // Held until reset
            LK_LOCKED: state_d = LK_LOCKED;
            default:   state_d = LK_IDLE;
        endcase
    end

    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            state_q <= LK_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Framing counter
    // Starts at 0 on the first nibble after the locking word,
    // runs 1..7 then 8, and 8 wraps back to 1
    always_ff @(posedge sysclk_i) begin
        if (rst_i || state_q != LK_LOCKED) begin
            seq_q <= 4'h0;
        end else begin
            seq_q <= {1'b0, seq_q[2:0]} + 4'h1;
        end
    end

    // Last nibble of an aligned word is in flight at position 7
    assign capture_w = (state_q == LK_LOCKED) && (seq_q[2:0] == 3'd7);

    always_ff @(posedge sysclk_i) begin
        if (capture_w) begin
            capture_q <= cand_w;
        end
    end

    // Oldest history nibble entered 7 cycles ago and its delayed copy 15
    srlvec #(
        .NBITS (CIN_NIB_W)
    ) u_err_dly (
        .sysclk_i (sysclk_i),
        .din_i    (hist_q[CIN_NIB_W-1:0]),
        .tap_i    (3'(CIN_NIBBLES - 1)),
        .dout_o   (oldest_dly_w)
    );

    // Hold off error flags until both compare paths carry
    // nibbles that entered after reset was asserted
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            prime_q <= 4'h0;
        end else if (prime_q != 4'hF) begin
            prime_q <= prime_q + 4'h1;
        end
    end

    // Compared only while unlocked because training may stop after lock
    always_ff @(posedge sysclk_i) begin
        if (rst_i || state_q == LK_LOCKED || prime_q != 4'hF) begin
            biterr_q <= 1'b0;
        end else begin
            biterr_q <= (hist_q[CIN_NIB_W-1:0] != oldest_dly_w);
        end
    end

    assign w.word   = capture_q;
    assign w.valid  = seq_q[3];
    assign w.locked = (state_q == LK_LOCKED);
    assign w.biterr = biterr_q;

    // No word may appear before lock
    a_valid_needs_lock: assert property (
        @(posedge sysclk_i) disable iff (rst_i)
        $rose(w.valid) |-> w.locked
    );

    // Lock is only ever lost through reset
    a_lock_sticky: assert property (
        @(posedge sysclk_i)
        $fell(w.locked) |-> $past(rst_i)
    );

    // Frame spacing fixed at 8 cycles once locked
    a_valid_period: assert property (
        @(posedge sysclk_i) disable iff (rst_i)
        w.valid |=> !w.valid [*7] ##1 w.valid
    );

endmodule

`default_nettype wire

/* src/cin_pkg.sv */
`default_nettype none

package cin_pkg;

    // Word geometry
    localparam int CIN_WORD_W   = 32;
    localparam int CIN_NIBBLES  = 8;
    localparam int CIN_NIB_W    = CIN_WORD_W / CIN_NIBBLES;
    // Nibble history kept ahead of the incoming nibble
    localparam int CIN_HIST_W   = CIN_WORD_W - CIN_NIB_W;

    // Repeating pattern the link locks onto
    localparam logic [CIN_WORD_W-1:0] CIN_TRAIN_WORD = 32'hA55A6996;

    // Bit error counter
    localparam int CIN_ERRCNT_W = 16;

    // Command word fields
    // Opcode in the top byte, payload below it
    localparam int CIN_OP_W     = 8;
    localparam int CIN_TAG_W    = 24;
    localparam int CIN_ADDR_W   = 8;
    localparam int CIN_DATA_W   = 16;

    // Top byte of a command word
    // Idle matches the top byte of the training word
    typedef enum logic [CIN_OP_W-1:0] {
        CIN_OP_TRIG   = 8'h01,
        CIN_OP_WRITE  = 8'h02,
        CIN_OP_RUNRST = 8'h03,
        CIN_OP_IDLE   = 8'hA5
    } cin_op_e;

    // Word lock progress
    typedef enum logic [1:0] {
        LK_IDLE,
        LK_ARMED,
        LK_LOCKED
    } cin_lock_e;

endpackage

`default_nettype wire

/* src/cin_word_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface cin_word_if;
    import cin_pkg::*;

    // Parallel word, held until the next capture
    logic [CIN_WORD_W-1:0] word;
    // One-cycle pulse per captured word
    logic                  valid;
    // Level, high once the link is locked
    logic                  locked;
    // One-cycle pulse per training nibble mismatch
    logic                  biterr;

    // Sync block side
    modport src (
        output word,
        output valid,
        output locked,
        output biterr
    );

    // Command decoder side
    modport dec (
        input word,
        input valid,
        input locked
    );

    // Error counter side
    modport err (
        input biterr,
        input locked
    );

endinterface

`default_nettype wire

/* src/srlvec.sv */
`timescale 1ns/1ps
`default_nettype none

module srlvec #(
    parameter int NBITS = 4
) (
    input  logic                                     sysclk_i,
    input  logic [NBITS-1:0]                         din_i,
    input  logic [$clog2(cin_pkg::CIN_NIBBLES)-1:0]  tap_i,
    output logic [NBITS-1:0]                         dout_o
);
    import cin_pkg::*;

    // One stage per nibble slot of a word
    logic [NBITS-1:0] stage_q [CIN_NIBBLES];

    // Straight shift every cycle, no enable
    always_ff @(posedge sysclk_i) begin
        stage_q[0] <= din_i;
        for (int i = 1; i < CIN_NIBBLES; i++) begin
            stage_q[i] <= stage_q[i-1];
        end
    end

    // Tap 0 is one cycle of delay, tap 7 is eight
    assign dout_o = stage_q[tap_i];

endmodule

`default_nettype wire

/* tb/tb_cin_link.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cin_link;
    import cin_pkg::*;

    // Stream lengths in words, per phase
    localparam int IDLE_WORDS  = 6;
    localparam int ERR_WORDS   = 24;
    localparam int LOCK_CORR   = 6;
    localparam int CMD_WORDS   = 40;
    localparam int BAD_WORDS   = 8;
    localparam int CMD2_WORDS  = 10;
    localparam int DRAIN_WORDS = 2;
    // Every word the stimulus sends including reset and lock words
    localparam int TOTAL_WORDS = 1 + IDLE_WORDS + ERR_WORDS + 4 + 2
                               + 1 + 4 + LOCK_CORR + DRAIN_WORDS
                               + CMD_WORDS + DRAIN_WORDS + BAD_WORDS + DRAIN_WORDS
                               + 1 + 1 + 3 + 1 + CMD2_WORDS + DRAIN_WORDS;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_WORDS * CIN_NIBBLES + 200;

    // Strobe vector order is trig, wr, runrst, bad_op
    localparam logic [3:0] K_TRIG = 4'b1000;
    localparam logic [3:0] K_WR   = 4'b0100;
    localparam logic [3:0] K_RUN  = 4'b0010;
    localparam logic [3:0] K_BAD  = 4'b0001;

    typedef struct packed {
        logic [3:0]            kind;
        logic [CIN_TAG_W-1:0]  tag;
        logic [CIN_ADDR_W-1:0] addr;
        logic [CIN_DATA_W-1:0] data;
    } exp_cmd_t;

    logic                    sysclk;
    logic                    rst;
    logic [3:0]              cin;
    logic                    lock_req;
    logic                    errcnt_clr;
    logic                    locked;
    logic [CIN_ERRCNT_W-1:0] errcnt;
    logic                    trig;
    logic [CIN_TAG_W-1:0]    trig_tag;
    logic                    wr;
    logic [CIN_ADDR_W-1:0]   wr_addr;
    logic [CIN_DATA_W-1:0]   wr_data;
    logic                    runrst;
    logic                    bad_op;

    // Scoreboard of commands still due from the decoder
    exp_cmd_t   sb_q [$];
    logic [3:0] nib_hist [CIN_NIBBLES];
    int         nib_count;
    int         exp_errcnt;
    logic       after_lock;
    logic [15:0] lfsr_q;
    int         error_count;
    int         check_count;
    int         cycle_count;

    cin_link_top dut0 (
        .sysclk_i     (sysclk),
        .rst_i        (rst),
        .cin_i        (cin),
        .lock_i       (lock_req),
        .errcnt_clr_i (errcnt_clr),
        .locked_o     (locked),
        .errcnt_o     (errcnt),
        .trig_o       (trig),
        .trig_tag_o   (trig_tag),
        .wr_o         (wr),
        .wr_addr_o    (wr_addr),
        .wr_data_o    (wr_data),
        .runrst_o     (runrst),
        .bad_op_o     (bad_op)
    );

    always #2 sysclk = ~sysclk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // Expected decoder response from the word layout
    function automatic exp_cmd_t expect_cmd(input logic [31:0] w);
        exp_cmd_t r;
        r = '0;
        case (w[31:24])
            CIN_OP_TRIG: begin
                r.kind = K_TRIG;
                r.tag  = w[23:0];
            end
            CIN_OP_WRITE: begin
                r.kind = K_WR;
                r.addr = w[23:16];
                r.data = w[15:0];
            end
            CIN_OP_RUNRST: r.kind = K_RUN;
            // Training filler gives no strobe
            CIN_OP_IDLE:   r.kind = 4'b0000;
            default:       r.kind = K_BAD;
        endcase
        return r;
    endfunction

    // Flip one random nibble to a different value
    function automatic logic [31:0] corrupt_nibble(input logic [31:0] w);
        logic [2:0] pos;
        logic [3:0] flip;
        pos  = rand_bits(3);
        flip = rand_bits(4);
        if (flip == 4'h0) begin
            flip = 4'h1;
        end
        return w ^ (32'(flip) << (4 * pos));
    endfunction

    function automatic logic [31:0] make_cmd();
        logic [1:0]  sel;
        logic [7:0]  op;
        logic [31:0] payload;
        sel = rand_bits(2);
        payload = rand_bits(24);
        case (sel)
            2'd1:    op = CIN_OP_WRITE;
            2'd2:    op = CIN_OP_RUNRST;
            default: op = CIN_OP_TRIG;
        endcase
        return {op, payload[23:0]};
    endfunction

    // Top byte kept outside the opcode set
    function automatic logic [31:0] make_bad_cmd();
        logic [7:0]  op;
        logic [31:0] payload;
        op = rand_bits(8);
        payload = rand_bits(24);
        if (op == CIN_OP_TRIG || op == CIN_OP_WRITE || op == CIN_OP_RUNRST
                || op == CIN_OP_IDLE) begin
            op = op ^ 8'h80;
        end
        return {op, payload[23:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Called on a falling edge and returns on the next one
    task automatic send_nibble(input logic [3:0] n);
        cin = n;
        // Training errors counted only while the link is unlocked
        if (nib_count >= CIN_NIBBLES && !after_lock && n != nib_hist[CIN_NIBBLES-1]) begin
            exp_errcnt++;
        end
        for (int i = CIN_NIBBLES - 1; i > 0; i--) begin
            nib_hist[i] = nib_hist[i-1];
        end
        nib_hist[0] = n;
        nib_count++;
        @(negedge sysclk);
    endtask

    // LS nibble first, and words after lock are due at the decoder
    task automatic send_word(input logic [31:0] w);
        exp_cmd_t e;
        if (after_lock) begin
            e = expect_cmd(w);
            if (e.kind != 4'b0000) begin
                sb_q.push_back(e);
            end
        end
        for (int i = 0; i < CIN_NIBBLES; i++) begin
            send_nibble(w[4*i +: 4]);
        end
    endtask

    task automatic send_idle(input int n);
        repeat (n) send_word(CIN_TRAIN_WORD);
    endtask

    // Reset over the first three nibbles of a training word
    task automatic reset_word();
        after_lock = 1'b0;
        exp_errcnt = 0;
        for (int i = 0; i < CIN_NIBBLES; i++) begin
            rst = (i < 3);
            send_nibble(CIN_TRAIN_WORD[4*i +: 4]);
        end
    endtask

    // Lock request on the first nibble and lock lands on its last
    task automatic lock_word();
        lock_req = 1'b1;
        send_word(CIN_TRAIN_WORD);
        lock_req = 1'b0;
        after_lock = 1'b1;
    endtask

    task automatic check_drained(input string phase);
        if (sb_q.size() != 0) begin
            error_count++;
            $display("After %s, %0d expected commands never came out", phase, sb_q.size());
            sb_q.delete();
        end
    endtask

    task automatic check_quiet();
        check_value("trig_o", trig, 0);
        check_value("wr_o", wr, 0);
        check_value("runrst_o", runrst, 0);
        check_value("bad_op_o", bad_op, 0);
    endtask

    // Scoreboard compare on the falling edge where outputs are stable
    always @(negedge sysclk) begin : compare_strobes
        logic [3:0] seen;
        exp_cmd_t   head;
        seen = {trig, wr, runrst, bad_op};
        if (seen !== 4'b0000) begin
            if (sb_q.size() == 0) begin
                error_count++;
                $display("Strobe %b came out with no command pending at %0t", seen, $time);
            end else begin
                head = sb_q.pop_front();
                check_value("strobes", seen, head.kind);
                if (head.kind == K_TRIG && trig) begin
                    check_value("trig_tag_o", trig_tag, head.tag);
                end
                if (head.kind == K_WR && wr) begin
                    check_value("wr_addr_o", wr_addr, head.addr);
                    check_value("wr_data_o", wr_data, head.data);
                end
            end
        end
    end

    always @(posedge sysclk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        sysclk = 1'b0;
        rst = 1'b1;
        cin = 4'h0;
        lock_req = 1'b0;
        errcnt_clr = 1'b0;
        after_lock = 1'b0;
        lfsr_q = 16'd24518;
        nib_count = 0;
        exp_errcnt = 0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        for (int i = 0; i < CIN_NIBBLES; i++) begin
            nib_hist[i] = 4'h0;
        end

        // Quiet after reset and clean training counts nothing
        reset_word();
        send_idle(IDLE_WORDS);
        check_value("locked_o", locked, 0);
        check_quiet();
        check_value("errcnt_o", errcnt, 0);

        // Corrupted training while unlocked
        for (int i = 0; i < ERR_WORDS; i++) begin
            if (rand_bits(1)) begin
                send_word(corrupt_nibble(CIN_TRAIN_WORD));
            end else begin
                send_word(CIN_TRAIN_WORD);
            end
        end
        send_idle(4);
        check_value("errcnt_o", errcnt, exp_errcnt);
        errcnt_clr = 1'b1;
        exp_errcnt = 0;
        send_word(CIN_TRAIN_WORD);
        errcnt_clr = 1'b0;
        send_idle(1);
        check_value("errcnt_o", errcnt, 0);

        // Lock, then training and corruption after lock
        lock_word();
        check_value("locked_o", locked, 1);
        send_idle(4);
        for (int i = 0; i < LOCK_CORR; i++) begin
            send_word(corrupt_nibble(CIN_TRAIN_WORD));
        end
        send_idle(DRAIN_WORDS);
        check_value("errcnt_o", errcnt, 0);
        check_drained("training after lock");

        // Random command mix
        for (int i = 0; i < CMD_WORDS; i++) begin
            send_word(make_cmd());
        end
        send_idle(DRAIN_WORDS);
        check_drained("command words");

        // Opcodes outside the set
        for (int i = 0; i < BAD_WORDS; i++) begin
            send_word(make_bad_cmd());
        end
        send_idle(DRAIN_WORDS);
        check_drained("bad opcodes");

        // Reset hits while a command word is still in flight
        // so its strobe must never show up
        after_lock = 1'b0;
        send_word(make_cmd());
        reset_word();
        check_value("locked_o", locked, 0);
        check_quiet();
        send_idle(3);
        lock_word();
        check_value("locked_o", locked, 1);
        for (int i = 0; i < CMD2_WORDS; i++) begin
            send_word(make_cmd());
        end
        send_idle(DRAIN_WORDS);
        check_drained("relock commands");

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
